// File: Bender.yml
package:
  name: legv8_core

sources:
  - include_dirs:
      - source
    files:
      - source/legv8_pkg.sv
      - source/rom_case.sv
      - source/instr_decoder.sv
      - source/reg_file.sv
      - source/alu.sv
      - source/dmem_io.sv
      - source/legv8_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/legv8_checker.sv
      - verif/legv8_tb.sv

// File: source/alu.sv
`timescale 1ns/10ps
`include "legv8_defs.svh"

module alu (
    input  logic [`LEGV8_XLEN-1:0] a,       // Rn
    input  logic [`LEGV8_XLEN-1:0] b,       // Rm, Rt or imm
    input  legv8_pkg::alu_op_t     op,
    output logic [`LEGV8_XLEN-1:0] result,
    output logic                   zero     // Drives CBZ and CBNZ
);
    import legv8_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_LSL: begin
                result = a << b[5:0];   // Shift range 0..63
            end
            ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

    // Decoder defaults keep op defined even for an undriven instruction
    op_known: assert final (!$isunknown(op))
        else $error("ALU op unknown");

endmodule

// File: source/dmem_io.sv
`timescale 1ns/10ps
`include "legv8_defs.svh"

module dmem_io (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`LEGV8_XLEN-1:0] addr,   // Byte address from ALU
    input  logic [`LEGV8_XLEN-1:0] wdata,
    input  logic                   rd_en,  // LDUR
    input  logic                   wr_en,  // STUR
    input  logic [`LEGV8_XLEN-1:0] sw,
    output logic [`LEGV8_XLEN-1:0] rdata,
    output logic [`LEGV8_XLEN-1:0] leds,
    output logic                   io_rd,  // Switch read strobe
    output logic                   io_wr   // Led write strobe
);
    localparam int DEPTH = `LEGV8_DMEM_WORDS;
    localparam int AW    = $clog2(DEPTH);
    localparam logic [`LEGV8_XLEN-1:0] RAM_BYTES = DEPTH * 8;
    localparam logic [`LEGV8_XLEN-1:0] SW_ADDR   = `LEGV8_IO_BASE;
    localparam logic [`LEGV8_XLEN-1:0] LED_ADDR  = `LEGV8_IO_BASE + 8;

    logic [`LEGV8_XLEN-1:0] ram [DEPTH];
    logic [AW-1:0]          word_idx;  // 8-byte word index
    logic                   sel_ram;
    logic                   sel_sw;
    logic                   sel_led;

    assign word_idx = addr[AW+2:3];
    assign sel_ram  = (addr < RAM_BYTES);
    assign sel_sw   = (addr == SW_ADDR);
    assign sel_led  = (addr == LED_ADDR);

    assign io_rd = rd_en & sel_sw;
    assign io_wr = wr_en & sel_led;

    always_comb begin
        if (sel_sw) begin
            rdata = sw;
        end else if (sel_ram) begin
            rdata = ram[word_idx];  // Asynchronous RAM read
        end else begin
            rdata = '0;             // Led register is write only
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && sel_ram) begin
            ram[word_idx] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            leds <= '0;
        end else if (io_wr) begin
            leds <= wdata;          // Visible after the STUR cycle
        end
    end

    // Program only touches aligned RAM words and the two I/O registers
    access_ok: assert property (@(posedge clk) disable iff (rst)
        (rd_en || wr_en) |-> (addr[2:0] == 3'b000) && (sel_ram || sel_sw || sel_led))
        else $error("bad data access at %h", addr);

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/10ps
`include "legv8_defs.svh"

module instr_decoder (
    input  logic [31:0]            instr,
    output logic [4:0]             rn,              // Port A index
    output logic [4:0]             rb,              // Port B index, Rm or Rt
    output logic [4:0]             rd,              // Write index
    output logic [`LEGV8_XLEN-1:0] imm,             // Extended and scaled
    output legv8_pkg::alu_op_t     alu_op,
    output logic                   alu_src_imm,     // ALU b from imm
    output logic                   reg_write,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   branch_zero,     // CBZ
    output logic                   branch_nonzero,  // CBNZ
    output logic                   branch_uncond,   // B
    output logic                   branch_reg       // BR
);
    import legv8_pkg::*;

    localparam int XLEN = `LEGV8_XLEN;

    logic [10:0] opc;       // Top opcode bits
    logic        rb_is_rd;  // STUR and CB test Rt on port B

    assign opc = instr[31:21];
    assign rn  = instr[9:5];
    assign rd  = instr[4:0];
    assign rb  = rb_is_rd ? instr[4:0] : instr[20:16];

    always_comb begin
        imm            = '0;       // Defaults form a no-op
        alu_op         = ALU_ADD;
        alu_src_imm    = 1'b0;
        reg_write      = 1'b0;
        mem_read       = 1'b0;
        mem_write      = 1'b0;
        branch_zero    = 1'b0;
        branch_nonzero = 1'b0;
        branch_uncond  = 1'b0;
        branch_reg     = 1'b0;
        rb_is_rd       = 1'b0;
        if (instr[31:26] == OP_B) begin
            imm           = {{(XLEN-28){instr[25]}}, instr[25:0], 2'b00};  // Word offset
            branch_uncond = 1'b1;
        end else begin
            casez (opc)
                OP_ADD, OP_SUB, OP_AND, OP_ORR: begin
                    reg_write = 1'b1;
                    case (opc)
                        OP_SUB:  alu_op = ALU_SUB;
                        OP_AND:  alu_op = ALU_AND;
                        OP_ORR:  alu_op = ALU_OR;
                        default: alu_op = ALU_ADD;
                    endcase
                end
                OP_LSL: begin
                    imm         = {{(XLEN-6){1'b0}}, instr[15:10]};  // shamt
                    alu_op      = ALU_LSL;
                    alu_src_imm = 1'b1;
                    reg_write   = 1'b1;
                end
                {OP_ADDI[10:1], 1'b?}, {OP_SUBI[10:1], 1'b?}: begin
                    imm         = {{(XLEN-12){1'b0}}, instr[21:10]};  // Unsigned ALU_imm
                    alu_op      = instr[30] ? ALU_SUB : ALU_ADD;      // Bit 30 marks SUBI
                    alu_src_imm = 1'b1;
                    reg_write   = 1'b1;
                end
                OP_LDUR, OP_STUR: begin
                    imm         = {{(XLEN-9){instr[20]}}, instr[20:12]};  // Byte offset
                    alu_src_imm = 1'b1;
                    reg_write   = instr[22];    // LDUR has bit 22 set
                    mem_read    = instr[22];
                    mem_write   = ~instr[22];
                    rb_is_rd    = ~instr[22];   // Store data comes from Rt
                end
                OP_MOVZ: begin
                    imm         = {{(XLEN-16){1'b0}}, instr[20:5]};
                    alu_op      = ALU_PASS_B;
                    alu_src_imm = 1'b1;
                    reg_write   = 1'b1;
                end
                {OP_CBZ[10:3], 3'b???}, {OP_CBNZ[10:3], 3'b???}: begin
                    imm            = {{(XLEN-21){instr[23]}}, instr[23:5], 2'b00};
                    alu_op         = ALU_PASS_B;  // zero flag tests Rt
                    rb_is_rd       = 1'b1;
                    branch_zero    = ~instr[24];
                    branch_nonzero = instr[24];
                end
                OP_BR: begin
                    branch_reg = 1'b1;          // Target from Rn
                end
                default: ;                      // Unknown, no-op
            endcase
        end
    end

    // Load and store never share an instruction
    rw_excl: assert final (!(mem_read && mem_write))
        else $error("decoder drives mem_read and mem_write together, instr %h", instr);

endmodule

// File: source/legv8_core.sv
`timescale 1ns/10ps
`include "legv8_defs.svh"

module legv8_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`LEGV8_XLEN-1:0] sw,     // Switch register input
    output logic [`LEGV8_XLEN-1:0] leds,
    output logic                   io_rd,
    output logic                   io_wr
);
    import legv8_pkg::*;

    localparam int XLEN = `LEGV8_XLEN;
    localparam int PCW  = `LEGV8_PC_WIDTH;

    logic [PCW-1:0]  pc;             // Byte address
    logic [PCW-1:0]  pc_plus4;
    logic [PCW-1:0]  pc_target;      // PC relative target
    logic [PCW-1:0]  pc_next;
    logic [15:0]     rom_addr;
    logic [31:0]     instr;
    logic [4:0]      rn;
    logic [4:0]      rb;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    alu_op_t         alu_op;
    logic            alu_src_imm;
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic            branch_zero;
    logic            branch_nonzero;
    logic            branch_uncond;
    logic            branch_reg;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] wb_data;
    logic            cb_taken;       // CBZ or CBNZ condition met

    assign rom_addr = 16'(pc >> 2);

    rom_case u_rom (
        .out     (instr),
        .address (rom_addr)
    );

    instr_decoder u_dec (
        .instr          (instr),
        .rn             (rn),
        .rb             (rb),
        .rd             (rd),
        .imm            (imm),
        .alu_op         (alu_op),
        .alu_src_imm    (alu_src_imm),
        .reg_write      (reg_write),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .branch_zero    (branch_zero),
        .branch_nonzero (branch_nonzero),
        .branch_uncond  (branch_uncond),
        .branch_reg     (branch_reg)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst     (rst),
        .ra      (rn),
        .rb      (rb),
        .wa      (rd),
        .wdata   (wb_data),
        .we      (reg_write),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    assign alu_b = alu_src_imm ? imm : rdata_b;

    alu u_alu (
        .a      (rdata_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    dmem_io u_dmem (
        .clk   (clk),
        .rst   (rst),
        .addr  (alu_result),
        .wdata (rdata_b),
        .rd_en (mem_read),
        .wr_en (mem_write),
        .sw    (sw),
        .rdata (mem_rdata),
        .leds  (leds),
        .io_rd (io_rd),
        .io_wr (io_wr)
    );

    assign wb_data = mem_read ? mem_rdata : alu_result;  // LDUR takes memory data

    // Next PC selection
    assign cb_taken  = (branch_zero & alu_zero) | (branch_nonzero & ~alu_zero);
    assign pc_plus4  = pc + PCW'(4);
    assign pc_target = pc + imm[PCW-1:0];  // Offset already scaled by 4

    always_comb begin
        if (branch_reg) begin
            pc_next = rdata_a[PCW-1:0];    // BR
        end else if (branch_uncond || cb_taken) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Branch targets from decoder and register file stay word aligned
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("PC misaligned at %h", pc);

endmodule

// File: source/legv8_defs.svh
`ifndef LEGV8_DEFS_SVH
`define LEGV8_DEFS_SVH

// Data path word, one register or one RAM word
`define LEGV8_XLEN 64

// PC holds a byte address, the ROM sees PC / 4
`define LEGV8_PC_WIDTH 16

// Switches at base, leds at base + 8
`define LEGV8_IO_BASE 256

// RAM depth in 8-byte words, fills bytes 0..255
`define LEGV8_DMEM_WORDS 32

`endif

// File: source/legv8_pkg.sv
package legv8_pkg;

    // ALU function select, driven by the decoder
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,  // Also address generation
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_LSL    = 3'd4,  // Shift by b[5:0]
        ALU_PASS_B = 3'd5   // MOVZ and CB register test
    } alu_op_t;

    // R format, instr[31:21]
    localparam logic [10:0] OP_ADD  = 11'b10001011000;
    localparam logic [10:0] OP_SUB  = 11'b11001011000;
    localparam logic [10:0] OP_AND  = 11'b10001010000;
    localparam logic [10:0] OP_ORR  = 11'b10101010000;
    localparam logic [10:0] OP_LSL  = 11'b11010011011;
    localparam logic [10:0] OP_BR   = 11'b11010110000;

    // I format opcode is 10 bits, lowest bit here is zero
    localparam logic [10:0] OP_ADDI = 11'b10010001000;
    localparam logic [10:0] OP_SUBI = 11'b11010001000;

    // D format
    localparam logic [10:0] OP_LDUR = 11'b11111000010;
    localparam logic [10:0] OP_STUR = 11'b11111000000;

    // IW format, hw field fixed at zero
    localparam logic [10:0] OP_MOVZ = 11'b11010010100;

    // CB opcode is 8 bits, low 3 bits here are zero
    localparam logic [10:0] OP_CBZ  = 11'b10110100000;
    localparam logic [10:0] OP_CBNZ = 11'b10110101000;

    // B format, instr[31:26]
    localparam logic [5:0]  OP_B    = 6'b000101;

endpackage

// File: source/reg_file.sv
`timescale 1ns/10ps
`include "legv8_defs.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [4:0]             ra,       // Read index A
    input  logic [4:0]             rb,       // Read index B
    input  logic [4:0]             wa,       // Write index
    input  logic [`LEGV8_XLEN-1:0] wdata,
    input  logic                   we,
    output logic [`LEGV8_XLEN-1:0] rdata_a,
    output logic [`LEGV8_XLEN-1:0] rdata_b
);
    localparam logic [4:0] XZR = 5'd31;

    logic [`LEGV8_XLEN-1:0] regs [32];

    // X31 always reads zero
    assign rdata_a = (ra == XZR) ? '0 : regs[ra];
    assign rdata_b = (rb == XZR) ? '0 : regs[rb];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != XZR)) begin  // Writes to XZR dropped
            regs[wa] <= wdata;
        end
    end

    // Write-back data is resolved by ALU or memory in the same cycle
    wdata_known: assert property (@(posedge clk) disable iff (rst)
        we |-> !$isunknown(wdata))
        else $error("register write of unknown data to X%0d", wa);

endmodule

// File: source/rom_case.sv
`timescale 1ns/10ps

module rom_case (
    output logic [31:0] out,     // Instruction word
    input  logic [15:0] address  // Word address, PC / 4
);
    import legv8_pkg::*;

    always_comb begin
        case (address)
            // X9 = I/O base
            16'd0:   out = {OP_MOVZ, 16'd256, 5'd9};
            // X1 = switches, loop target
            16'd1:   out = {OP_LDUR, 9'd0, 2'b00, 5'd9, 5'd1};
            // X2 = 2s
            16'd2:   out = {OP_ADD, 5'd1, 6'd0, 5'd1, 5'd2};
            // X3 = 16s
            16'd3:   out = {OP_LSL, 5'd0, 6'd4, 5'd1, 5'd3};
            // X4 = 15s
            16'd4:   out = {OP_SUB, 5'd1, 6'd0, 5'd3, 5'd4};
            16'd5:   out = {OP_ADDI[10:1], 12'd7, 5'd4, 5'd4};
            // X5 = (15s + 7) | 2s
            16'd6:   out = {OP_ORR, 5'd2, 6'd0, 5'd4, 5'd5};
            // First led write
            16'd7:   out = {OP_STUR, 9'd8, 2'b00, 5'd9, 5'd5};
            // Round trip through RAM word 2
            16'd8:   out = {OP_STUR, 9'd16, 2'b00, 5'd31, 5'd1};
            16'd9:   out = {OP_LDUR, 9'd16, 2'b00, 5'd31, 5'd6};
            // Zero switch skips word 11
            16'd10:  out = {OP_CBZ[10:3], 19'd2, 5'd6};
            // Second led write, s itself
            16'd11:  out = {OP_STUR, 9'd8, 2'b00, 5'd9, 5'd6};
            // B -11, back to word 1
            16'd12:  out = {OP_B, 26'h3fffff5};
            // BR XZR, runaway PC restarts at 0
            default: out = {OP_BR, 5'd0, 6'd0, 5'd31, 5'd0};
        endcase
    end

endmodule

// File: verif/legv8_checker.sv
`timescale 1ns/10ps
`include "legv8_defs.svh"

module legv8_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`LEGV8_XLEN-1:0] sw,
    input  logic                   io_rd,
    input  logic                   io_wr,
    input  logic [`LEGV8_XLEN-1:0] leds,
    output int                     error_count
);
    localparam int XLEN = `LEGV8_XLEN;

    logic [XLEN-1:0] s;            // Switch value of the current loop
    logic [XLEN-1:0] led_exp;      // Value leds must show next cycle
    logic            led_pending;
    logic            loop_active;  // Seen an io_rd since reset
    logic            after_rst;    // First cycle out of reset
    int              gap;          // Cycles since last io_rd
    int              writes;       // Led writes in this loop

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                   input logic [XLEN-1:0] got);
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
        error_count++;
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    initial begin
        error_count = 0;
        led_pending = 1'b0;
        loop_active = 1'b0;
        after_rst   = 1'b0;
        gap         = 0;
        writes      = 0;
        s           = '0;
        led_exp     = '0;
    end

    always @(posedge clk) begin
        if (rst) begin
            led_pending <= 1'b0;   // Loop in flight is abandoned
            loop_active <= 1'b0;
            after_rst   <= 1'b1;
        end else begin
            if (after_rst && leds !== '0) begin
                report_mismatch("leds after reset", '0, leds);
            end
            after_rst <= 1'b0;
            if (led_pending && leds !== led_exp) begin
                report_mismatch("leds", led_exp, leds);
            end
            led_pending <= 1'b0;
            if (io_rd) begin
                if (loop_active) begin
                    // Close out the previous loop
                    if (writes != ((s != '0) ? 2 : 1)) begin
                        report_error($sformatf("loop with switch %h made %0d led writes",
                                               s, writes));
                    end
                    if (gap + 1 != ((s == '0) ? 11 : 12)) begin
                        report_mismatch("io_rd interval", (s == '0) ? 11 : 12, gap + 1);
                    end
                end
                s           <= sw;
                loop_active <= 1'b1;
                gap         <= 0;
                writes      <= 0;
            end else begin
                gap <= gap + 1;
            end
            if (io_wr) begin
                if (!loop_active || io_rd) begin
                    report_error("led write with no switch read before it");
                end else if (writes == 0) begin
                    led_exp     <= ((s * 15) + 7) | (s * 2);  // First result of the loop
                    led_pending <= 1'b1;
                    writes      <= writes + 1;
                end else if (writes == 1 && s != '0) begin
                    led_exp     <= s;                       // RAM round trip copy
                    led_pending <= 1'b1;
                    writes      <= writes + 1;
                end else begin
                    report_error($sformatf("extra led write in loop with switch %h", s));
                    writes <= writes + 1;
                end
            end
        end
    end

endmodule

// File: verif/legv8_tb.sv
`timescale 1ns/10ps
`include "legv8_defs.svh"

module legv8_tb;

    localparam logic [31:0] SEED = 32'hbf6ef028;

    logic                   clk;
    logic                   rst;
    logic [`LEGV8_XLEN-1:0] sw;
    logic [`LEGV8_XLEN-1:0] leds;
    logic                   io_rd;
    logic                   io_wr;
    logic [31:0]            lfsr;
    int                     chk_errors;
    int                     tb_errors;
    int                     total;
    bit                     timed_out;

    legv8_core dut (
        .clk   (clk),
        .rst   (rst),
        .sw    (sw),
        .leds  (leds),
        .io_rd (io_rd),
        .io_wr (io_wr)
    );

    legv8_checker u_chk (
        .clk         (clk),
        .rst         (rst),
        .sw          (sw),
        .io_rd       (io_rd),
        .io_wr       (io_wr),
        .leds        (leds),
        .error_count (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    // Taps 32, 22, 2, 1
    function automatic logic step_lfsr();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], step_lfsr()};
        end
        return v;
    endfunction

    function automatic logic [`LEGV8_XLEN-1:0] next_switch_value();
        logic [31:0] bits;
        bits = random_bits(3);
        if (bits[2:0] == 3'd0) begin
            return '0;             // Zero path, CBZ taken
        end
        bits = random_bits(16);
        return {{(`LEGV8_XLEN-16){1'b0}}, bits[15:0]};
    endfunction

    task automatic wait_for_io_rd(input int limit, input string when);
        int  n;
        bit  seen;
        n    = 0;
        seen = 0;
        while (!seen && n < limit) begin
            @(posedge clk);
            n++;
            seen = io_rd;
        end
        if (!seen) begin
            $display("error at %0t: switch read never arrived %s", $time, when);
            tb_errors++;
            timed_out = 1;
        end
    endtask

    task automatic wait_for_io_wr(input int limit);
        int  n;
        bit  seen;
        n    = 0;
        seen = 0;
        while (!seen && n < limit) begin
            @(posedge clk);
            n++;
            seen = io_wr;
        end
        if (!seen) begin
            $display("error at %0t: the expected led write never arrived", $time);
            tb_errors++;
            timed_out = 1;
        end
    endtask

    // Called 1 ns after an edge with rst just released
    task automatic run_program(input int loops);
        logic [`LEGV8_XLEN-1:0] cur;
        int                     writes;
        int                     i;
        int                     k;
        cur = next_switch_value();
        sw  = cur;
        wait_for_io_rd(2, "within 2 cycles of reset release");
        for (i = 0; i < loops && !timed_out; i++) begin
            writes = (cur != '0) ? 2 : 1;
            for (k = 0; k < writes && !timed_out; k++) begin
                wait_for_io_wr(12);
            end
            if (!timed_out) begin
                #1;
                cur = next_switch_value();   // New value for the next LDUR
                sw  = cur;
                wait_for_io_rd(13, "at the start of the next loop");
            end
        end
    endtask

    initial begin
        lfsr      = SEED;
        rst       = 1'b1;
        sw        = '0;
        tb_errors = 0;
        timed_out = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        run_program(20);
        if (!timed_out) begin
            @(posedge clk);
            #1;
            rst = 1'b1;                  // Reset in the middle of a loop
            repeat (16) @(posedge clk);
            #1;
            rst = 1'b0;
            run_program(12);
        end
        @(posedge clk);
        total = tb_errors + chk_errors;
        $display("errors: %0d (checker %0d, testbench %0d)", total, chk_errors, tb_errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+source
source/legv8_pkg.sv
source/rom_case.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/dmem_io.sv
source/legv8_core.sv
verif/legv8_checker.sv
verif/legv8_tb.sv
